//--- verilog/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    //////////////////////////////////////////////////////////////////////
    // geometry
    //////////////////////////////////////////////////////////////////////

    localparam int num_ways     = 2;
    localparam int index_width  = 4;
    localparam int offset_width = 2;
    localparam int tag_width    = 32 - index_width - offset_width - 2;
    localparam int line_width   = 128;
    localparam int num_sets     = 1 << index_width;

    // memory bus size codes
    localparam logic [1:0] size_word = 2'd2;
    localparam logic [1:0] size_line = 2'd3;

    //////////////////////////////////////////////////////////////////////
    // pipeline side
    //////////////////////////////////////////////////////////////////////

    // 32-bit address, fields split out
    typedef struct packed {
        logic [tag_width-1:0]    tag;
        logic [index_width-1:0]  index;
        logic [offset_width-1:0] offset;
        logic [1:0]              byte_sel;
    } addr_t;

    typedef struct packed {
        addr_t       addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        is_write;
        // op: invalidate the addressed set
        logic        is_op;
    } cpu_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
    } cpu_resp_t;

    //////////////////////////////////////////////////////////////////////
    // memory side
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic        req;
        logic        wr;
        logic [1:0]  size;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } mem_req_t;

    typedef struct packed {
        logic                  addr_ok;
        logic                  data_ok;
        logic [line_width-1:0] rdata;
    } mem_resp_t;

    //////////////////////////////////////////////////////////////////////
    // storage and control
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                 valid;
        logic [tag_width-1:0] tag;
    } tagv_t;

    typedef logic [line_width-1:0] line_t;

    typedef struct packed {
        logic                buf_load;
        // per way, shared by tag and data arrays
        logic [num_ways-1:0] way_we;
        logic                refill;
        logic                fwd_return;
        logic                lru_touch;
        logic                touch_way;
        logic                inval;
    } ctrl_t;

endpackage

`default_nettype wire

//--- verilog/dcache_ram.sv
`default_nettype none

module dcache_ram #(
    parameter type entry_t = dcache_pkg::line_t
) (
    input  wire                               clk,
    input  wire                               rstn,
    input  wire [dcache_pkg::index_width-1:0] index,
    input  wire                               we,
    input  wire                               clear,
    input  wire entry_t                       wentry,
    output entry_t                            rentry
);

    entry_t mem [dcache_pkg::num_sets];

    // clear wins over write, drops the valid bit on invalidate
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < dcache_pkg::num_sets; i++) begin
                mem[i] <= '0;
            end
        end else if (clear) begin
            mem[index] <= '0;
        end else if (we) begin
            mem[index] <= wentry;
        end
    end

    // combinational read
    assign rentry = mem[index];

endmodule

`default_nettype wire

//--- verilog/dcache_lru.sv
`default_nettype none

module dcache_lru (
    input  wire                               clk,
    input  wire                               rstn,
    input  wire [dcache_pkg::index_width-1:0] index,
    input  wire                               touch,
    input  wire                               touch_way,
    output logic                              victim_way
);

    // one bit per set, points at the way to evict next
    logic [dcache_pkg::num_sets-1:0] lru_bits;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lru_bits <= '0;
        end else if (touch) begin
            lru_bits[index] <= ~touch_way;
        end
    end

    assign victim_way = lru_bits[index];

endmodule

`default_nettype wire

//--- verilog/dcache_req_buf.sv
`default_nettype none

module dcache_req_buf (
    input  wire                 clk,
    input  wire                 rstn,
    input  wire                 load,
    input  wire dcache_pkg::cpu_req_t req_in,
    output dcache_pkg::cpu_req_t     req_out
);

    dcache_pkg::cpu_req_t req_q;

    // holds the accepted request until the next acceptance, so the word
    // offset is still there when a refill line comes back
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            req_q <= '0;
        end else if (load) begin
            req_q <= req_in;
        end
    end

    assign req_out = req_q;

endmodule

`default_nettype wire

//--- verilog/dcache_datapath.sv
`default_nettype none

module dcache_datapath (
    input  wire dcache_pkg::cpu_req_t                         req,
    input  wire dcache_pkg::tagv_t [dcache_pkg::num_ways-1:0] tagv,
    input  wire dcache_pkg::line_t [dcache_pkg::num_ways-1:0] lines,
    input  wire dcache_pkg::line_t                            mem_rdata,
    input  wire                                               fwd_return,
    input  wire                                               refill,
    output logic [dcache_pkg::num_ways-1:0]                   hit,
    output logic [31:0]                                       rdata,
    output dcache_pkg::line_t                                 wline,
    output dcache_pkg::tagv_t                                 wtagv
);

    dcache_pkg::line_t hit_line;
    dcache_pkg::line_t src_line;
    dcache_pkg::line_t merged;

    // tag compare
    always_comb begin
        for (int w = 0; w < dcache_pkg::num_ways; w++) begin
            hit[w] = tagv[w].valid && (tagv[w].tag == req.addr.tag);
        end
    end

    assign hit_line = hit[1] ? lines[1] : lines[0];

    // forwarded refill word takes priority over the cached line
    assign src_line = fwd_return ? mem_rdata : hit_line;
    assign rdata    = src_line[req.addr.offset * 32 +: 32];

    // byte merge into the addressed word
    always_comb begin
        merged = hit_line;
        for (int b = 0; b < 4; b++) begin
            if (req.wstrb[b]) begin
                merged[(req.addr.offset * 4 + b) * 8 +: 8] = req.wdata[b * 8 +: 8];
            end
        end
    end

    assign wline       = refill ? mem_rdata : merged;
    assign wtagv.valid = 1'b1;
    assign wtagv.tag   = req.addr.tag;

endmodule

`default_nettype wire

//--- verilog/dcache_ctrl.sv
`default_nettype none

module dcache_ctrl (
    input  wire                            clk,
    input  wire                            rstn,
    input  wire                            req_valid,
    input  wire                            is_op,
    output logic                           req_ready,
    input  wire [dcache_pkg::num_ways-1:0] hit,
    input  wire                            buf_is_write,
    input  wire                            victim_way,
    input  wire                            mem_addr_ok,
    input  wire                            mem_data_ok,
    output logic                           mem_req,
    output logic                           mem_wr,
    output logic                           mem_line,
    output logic                           resp_valid,
    output dcache_pkg::ctrl_t              ctrl
);

    typedef enum logic [2:0] {
        s_idle,
        s_lookup,
        s_operation,
        s_hit_w,
        s_miss_w,
        s_miss_r,
        s_miss_r_wait,
        s_replace
    } state_t;

    state_t state;
    state_t next_state;
    state_t accept_state;
    logic   any_hit;
    // request taken in the data_ok cycle, run after replace
    logic   held_valid;
    logic   held_op;

    assign any_hit = |hit;

    // where a cycle with ready high goes
    assign accept_state = !req_valid ? s_idle : (is_op ? s_operation : s_lookup);

    //////////////////////////////////////////////////////////////////////
    // state register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= s_idle;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            held_valid <= 1'b0;
            held_op    <= 1'b0;
        end else if (state == s_miss_r_wait && mem_data_ok) begin
            held_valid <= req_valid;
            held_op    <= is_op;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            s_idle: begin
                next_state = accept_state;
            end
            s_lookup: begin
                if (any_hit) begin
                    next_state = buf_is_write ? s_hit_w : accept_state;
                end else if (buf_is_write) begin
                    next_state = s_miss_w;
                end else begin
                    // line read already issued from this cycle
                    next_state = mem_addr_ok ? s_miss_r_wait : s_miss_r;
                end
            end
            s_operation: begin
                next_state = s_idle;
            end
            s_hit_w, s_miss_w: begin
                if (mem_addr_ok) begin
                    next_state = accept_state;
                end
            end
            s_miss_r: begin
                if (mem_addr_ok) begin
                    next_state = s_miss_r_wait;
                end
            end
            s_miss_r_wait: begin
                if (mem_data_ok) begin
                    next_state = s_replace;
                end
            end
            s_replace: begin
                if (!held_valid) begin
                    next_state = s_idle;
                end else begin
                    next_state = held_op ? s_operation : s_lookup;
                end
            end
            default: begin
                next_state = s_idle;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // output decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        req_ready  = 1'b0;
        mem_req    = 1'b0;
        mem_wr     = 1'b0;
        mem_line   = 1'b0;
        resp_valid = 1'b0;
        ctrl       = '0;
        case (state)
            s_idle: begin
                req_ready = 1'b1;
            end
            s_lookup: begin
                if (any_hit) begin
                    ctrl.lru_touch = 1'b1;
                    ctrl.touch_way = hit[1];
                    if (buf_is_write) begin
                        // merge strobed bytes into the hit way
                        ctrl.way_we = hit;
                    end else begin
                        resp_valid = 1'b1;
                        req_ready  = 1'b1;
                    end
                end else if (next_state == s_miss_r || next_state == s_miss_r_wait) begin
                    mem_req  = 1'b1;
                    mem_line = 1'b1;
                end
            end
            s_operation: begin
                ctrl.inval = 1'b1;
            end
            s_hit_w, s_miss_w: begin
                mem_req   = 1'b1;
                mem_wr    = 1'b1;
                req_ready = mem_addr_ok;
            end
            s_miss_r: begin
                mem_req  = 1'b1;
                mem_line = 1'b1;
            end
            s_miss_r_wait: begin
                if (next_state == s_replace) begin
                    // returned line: forward the word and fill the victim
                    resp_valid              = 1'b1;
                    req_ready               = 1'b1;
                    ctrl.fwd_return         = 1'b1;
                    ctrl.refill             = 1'b1;
                    ctrl.way_we[victim_way] = 1'b1;
                    ctrl.lru_touch          = 1'b1;
                    ctrl.touch_way          = victim_way;
                end
            end
            default: begin
            end
        endcase
        ctrl.buf_load = req_ready & req_valid;
    end

endmodule

`default_nettype wire

//--- verilog/dcache_top.sv
`default_nettype none

module dcache_top (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire                        req_valid,
    input  wire dcache_pkg::cpu_req_t  req,
    output logic                       req_ready,
    output dcache_pkg::cpu_resp_t      resp,
    output dcache_pkg::mem_req_t       mem_out,
    input  wire dcache_pkg::mem_resp_t mem_in
);

    dcache_pkg::cpu_req_t                         req_q;
    dcache_pkg::ctrl_t                            ctrl;
    dcache_pkg::tagv_t [dcache_pkg::num_ways-1:0] tagv;
    dcache_pkg::line_t [dcache_pkg::num_ways-1:0] lines;
    dcache_pkg::tagv_t                            wtagv;
    dcache_pkg::line_t                            wline;
    dcache_pkg::addr_t                            line_addr;
    dcache_pkg::addr_t                            word_addr;
    logic [dcache_pkg::num_ways-1:0]              hit;
    logic [31:0]                                  rdata;
    logic                                         victim_way;
    logic                                         mem_req;
    logic                                         mem_wr;
    logic                                         mem_line;
    logic                                         resp_valid;

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////

    dcache_ctrl u_ctrl (
        .clk         (clk),
        .rstn        (rstn),
        .req_valid   (req_valid),
        .is_op       (req.is_op),
        .req_ready   (req_ready),
        .hit         (hit),
        .buf_is_write(req_q.is_write),
        .victim_way  (victim_way),
        .mem_addr_ok (mem_in.addr_ok),
        .mem_data_ok (mem_in.data_ok),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .mem_line    (mem_line),
        .resp_valid  (resp_valid),
        .ctrl        (ctrl)
    );

    dcache_req_buf u_req_buf (
        .clk    (clk),
        .rstn   (rstn),
        .load   (ctrl.buf_load),
        .req_in (req),
        .req_out(req_q)
    );

    dcache_lru u_lru (
        .clk       (clk),
        .rstn      (rstn),
        .index     (req_q.addr.index),
        .touch     (ctrl.lru_touch),
        .touch_way (ctrl.touch_way),
        .victim_way(victim_way)
    );

    //////////////////////////////////////////////////////////////////////
    // storage, tag/valid and data per way
    //////////////////////////////////////////////////////////////////////

    for (genvar w = 0; w < dcache_pkg::num_ways; w++) begin : g_way
        dcache_ram #(
            .entry_t(dcache_pkg::tagv_t)
        ) u_tagv (
            .clk   (clk),
            .rstn  (rstn),
            .index (req_q.addr.index),
            .we    (ctrl.way_we[w]),
            .clear (ctrl.inval),
            .wentry(wtagv),
            .rentry(tagv[w])
        );

        dcache_ram #(
            .entry_t(dcache_pkg::line_t)
        ) u_data (
            .clk   (clk),
            .rstn  (rstn),
            .index (req_q.addr.index),
            .we    (ctrl.way_we[w]),
            .clear (ctrl.inval),
            .wentry(wline),
            .rentry(lines[w])
        );
    end

    dcache_datapath u_datapath (
        .req       (req_q),
        .tagv      (tagv),
        .lines     (lines),
        .mem_rdata (mem_in.rdata),
        .fwd_return(ctrl.fwd_return),
        .refill    (ctrl.refill),
        .hit       (hit),
        .rdata     (rdata),
        .wline     (wline),
        .wtagv     (wtagv)
    );

    //////////////////////////////////////////////////////////////////////
    // memory request
    //////////////////////////////////////////////////////////////////////

    // line read is line aligned, a write is word aligned
    always_comb begin
        line_addr          = req_q.addr;
        line_addr.offset   = '0;
        line_addr.byte_sel = '0;
        word_addr          = req_q.addr;
        word_addr.byte_sel = '0;
    end

    assign mem_out.req   = mem_req;
    assign mem_out.wr    = mem_wr;
    assign mem_out.size  = mem_line ? dcache_pkg::size_line : dcache_pkg::size_word;
    assign mem_out.addr  = mem_line ? line_addr : word_addr;
    assign mem_out.wdata = req_q.wdata;
    assign mem_out.wstrb = mem_wr ? req_q.wstrb : 4'b0000;

    assign resp.valid = resp_valid;
    assign resp.rdata = rdata;

endmodule

`default_nettype wire

//--- verification/dcache_clk_gen.sv
`default_nettype none

module dcache_clk_gen (
    output logic clk,
    output logic rstn
);

    timeunit 1ns;
    timeprecision 100ps;

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held for two clock cycles
    initial begin
        rstn = 1'b0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/dcache_tb.sv
`default_nettype none

module dcache_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int wait_limit = 64;

    wire clk;
    wire rstn;

    logic                  req_valid;
    dcache_pkg::cpu_req_t  req;
    logic                  req_ready;
    dcache_pkg::cpu_resp_t resp;
    dcache_pkg::mem_req_t  mem_out;
    dcache_pkg::mem_resp_t mem_in = '0;

    // memory model state
    logic [31:0]          mem_words [logic [31:0]];
    dcache_pkg::mem_req_t bus_seen = '0;
    logic                 hold_prev = 1'b0;
    logic [31:0]          rng_state = 32'd89;
    logic [31:0]          pend_addr = '0;
    logic                 addr_armed = 1'b0;
    int                   addr_delay = 0;
    int                   data_wait = 0;

    // what memory saw, for the per-op checks
    int          line_reads = 0;
    int          write_count = 0;
    logic [31:0] last_line_addr = '0;
    logic [1:0]  last_line_size = '0;
    logic [31:0] last_wr_addr = '0;
    logic [31:0] last_wr_data = '0;
    logic [3:0]  last_wr_strb = '0;
    logic [1:0]  last_wr_size = '0;

    // hit read accepted, its response is due in the next cycle
    logic        pend_hit = 1'b0;
    logic [31:0] pend_rdata = '0;

    int   value_errs = 0;
    int   other_errs = 0;
    int   ops_run = 0;
    logic aborted = 1'b0;

    dcache_clk_gen u_clk_gen (
        .clk (clk),
        .rstn(rstn)
    );

    dcache_top i_dut (
        .clk      (clk),
        .rstn     (rstn),
        .req_valid(req_valid),
        .req      (req),
        .req_ready(req_ready),
        .resp     (resp),
        .mem_out  (mem_out),
        .mem_in   (mem_in)
    );

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // untouched words read back as the inverted address
    function automatic logic [31:0] word_at(input logic [31:0] a);
        if (mem_words.exists(a)) begin
            return mem_words[a];
        end
        return ~a;
    endfunction

    function automatic dcache_pkg::line_t line_at(input logic [31:0] base);
        return {word_at(base + 32'd12), word_at(base + 32'd8), word_at(base + 32'd4), word_at(base)};
    endfunction

    function automatic void store_word(input logic [31:0] a, input logic [31:0] d,
                                       input logic [3:0] strb);
        logic [31:0] w;
        w = word_at(a);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                w[b*8 +: 8] = d[b*8 +: 8];
            end
        end
        mem_words[a] = w;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_timeout(input string what);
        other_errs++;
        aborted = 1'b1;
        $display("timeout while waiting for %s at %0t", what, $time);
    endtask

    // one cycle, sampled at the falling edge where outputs have settled
    task automatic tick();
        @(negedge clk);
        // a request not yet taken must not move
        if (hold_prev) begin
            compare("mem_out.addr", mem_out.addr, bus_seen.addr);
            compare("mem_out.wdata", mem_out.wdata, bus_seen.wdata);
            compare("mem_out.req/wr/size/wstrb",
                    32'({mem_out.req, mem_out.wr, mem_out.size, mem_out.wstrb}),
                    32'({bus_seen.req, bus_seen.wr, bus_seen.size, bus_seen.wstrb}));
        end
        if (mem_out.req && !mem_in.addr_ok) begin
            compare("req_ready", 32'(req_ready), 32'd0);
        end
        if (data_wait > 0) begin
            compare("req_ready", 32'(req_ready), 32'd0);
        end
        hold_prev = mem_out.req && !mem_in.addr_ok;
        bus_seen  = mem_out;
    endtask

    // lookup cycle of a hit read: data out and ready for the next request
    task automatic check_hit_resp();
        compare("resp.valid", 32'(resp.valid), 32'd1);
        compare("resp.rdata", resp.rdata, pend_rdata);
        compare("req_ready", 32'(req_ready), 32'd1);
        pend_hit = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // memory model, uses the bus as sampled on the last falling edge
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rstn) begin
            mem_in     <= '0;
            addr_armed = 1'b0;
            data_wait  = 0;
        end else begin
            mem_in.data_ok <= 1'b0;
            if (data_wait > 0) begin
                data_wait = data_wait - 1;
                if (data_wait == 0) begin
                    mem_in.data_ok <= 1'b1;
                    mem_in.rdata   <= line_at(pend_addr);
                end
            end
            if (bus_seen.req && mem_in.addr_ok) begin
                // handshake completes on this edge
                mem_in.addr_ok <= 1'b0;
                addr_armed = 1'b0;
                if (bus_seen.wr) begin
                    store_word(bus_seen.addr, bus_seen.wdata, bus_seen.wstrb);
                    last_wr_addr = bus_seen.addr;
                    last_wr_data = bus_seen.wdata;
                    last_wr_strb = bus_seen.wstrb;
                    last_wr_size = bus_seen.size;
                    write_count++;
                end else begin
                    pend_addr      = bus_seen.addr;
                    last_line_addr = bus_seen.addr;
                    last_line_size = bus_seen.size;
                    line_reads++;
                    rng_state = xorshift(rng_state);
                    data_wait = 2 + int'(rng_state % 4);
                end
            end else if (bus_seen.req) begin
                if (!addr_armed) begin
                    rng_state  = xorshift(rng_state);
                    addr_delay = int'(rng_state % 4);
                    addr_armed = 1'b1;
                end
                if (addr_delay == 0) begin
                    mem_in.addr_ok <= 1'b1;
                end else begin
                    addr_delay--;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // one operation from the stimulus file
    //////////////////////////////////////////////////////////////////////

    task automatic run_op(input byte op, input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] wstrb, input logic [31:0] exp_rdata,
                          input int exp_lines);
        int reads_before;
        int writes_before;
        int cycles;
        reads_before  = line_reads;
        writes_before = write_count;
        // after a hit this is still the edge that took it, so the requests run back to back
        if (!pend_hit) begin
            @(posedge clk);
        end
        req_valid    <= 1'b1;
        req.addr     <= addr;
        req.wdata    <= wdata;
        req.wstrb    <= wstrb;
        req.is_write <= (op == "w");
        req.is_op    <= (op == "i");
        cycles = 0;
        do begin
            tick();
            if (cycles == 0) begin
                reads_before  = line_reads;
                writes_before = write_count;
            end
            if (pend_hit) begin
                check_hit_resp();
            end
            cycles++;
        end while (!req_ready && cycles < wait_limit);
        if (!req_ready) begin
            report_timeout("the request to be accepted");
            return;
        end
        @(posedge clk);
        if (op == "r" && exp_lines == 0) begin
            // request stays valid until the next one replaces it
            pend_hit   = 1'b1;
            pend_rdata = exp_rdata;
            return;
        end
        req_valid <= 1'b0;
        cycles = 0;
        if (op == "r") begin
            do begin
                tick();
                cycles++;
            end while (!resp.valid && cycles < wait_limit);
            if (!resp.valid) begin
                report_timeout("the read response");
                return;
            end
            compare("resp.rdata", resp.rdata, exp_rdata);
            // refill cycle takes the next request
            compare("req_ready", 32'(req_ready), 32'd1);
        end else if (op == "w") begin
            do begin
                tick();
                cycles++;
            end while (write_count == writes_before && cycles < wait_limit);
            if (write_count == writes_before) begin
                report_timeout("the memory write");
                return;
            end
            compare("mem_out.addr", last_wr_addr, {addr[31:2], 2'b00});
            compare("mem_out.wdata", last_wr_data, wdata);
            compare("mem_out.wstrb", 32'(last_wr_strb), 32'(wstrb));
            compare("mem_out.size", 32'(last_wr_size), 32'd2);
        end else begin
            do begin
                tick();
                cycles++;
            end while (!req_ready && cycles < wait_limit);
            if (!req_ready) begin
                report_timeout("the end of the invalidate");
                return;
            end
            // clear in the cycle after acceptance, ready again one cycle later
            compare("invalidate cycles", 32'(cycles), 32'd2);
        end
        compare("line reads", 32'(line_reads - reads_before), 32'(exp_lines));
        if (exp_lines == 1 && line_reads > reads_before) begin
            compare("mem_out.addr", last_line_addr, {addr[31:4], 4'h0});
            compare("mem_out.size", 32'(last_line_size), 32'd3);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int          fd;
        int          n;
        int          t;
        string       line;
        byte         op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic [31:0] exp_rdata;
        int          exp_lines;
        req_valid = 1'b0;
        req       = '0;
        t = 0;
        while (rstn !== 1'b1 && t < wait_limit) begin
            @(posedge clk);
            t++;
        end
        if (rstn !== 1'b1) begin
            report_timeout("reset release");
        end
        fd = $fopen("verification/dcache_input.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("could not open the stimulus file verification/dcache_input.txt");
        end else begin
            while (!$feof(fd) && !aborted) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() < 4 || line[0] == "#") begin
                    continue;
                end
                op = line[0];
                n = $sscanf(line.substr(2, line.len() - 1), "%h %h %h %h %d",
                            addr, wdata, wstrb, exp_rdata, exp_lines);
                if (n != 5 || (op != "r" && op != "w" && op != "i")) begin
                    other_errs++;
                    $display("malformed stimulus line: %s", line);
                    continue;
                end
                run_op(op, addr, wdata, wstrb, exp_rdata, exp_lines);
                ops_run++;
            end
            $fclose(fd);
        end
        // last hit read has nothing behind it
        if (pend_hit) begin
            req_valid <= 1'b0;
            tick();
            check_hit_resp();
        end
        if (ops_run == 0) begin
            other_errs++;
            $display("no operations were run from the stimulus file");
        end
        $display("errors: %0d value mismatches, %0d other failures, %0d ops run",
                 value_errs, other_errs, ops_run);
        if (value_errs == 0 && other_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/dcache_input.txt
# op addr wdata wstrb exp_rdata line_reads (hex except line_reads)
# op: r read, w write, i invalidate the set; unused fields are zero
r 00001004 00000000 0 ffffeffb 1
r 00001000 00000000 0 ffffefff 0
r 0000100c 00000000 0 ffffeff3 0
r 00001008 00000000 0 ffffeff7 0
w 00001008 12345678 3 00000000 0
r 00001008 00000000 0 ffff5678 0
w 00002014 cafef00d c 00000000 0
r 00002014 00000000 0 cafedfeb 1
r 00002014 00000000 0 cafedfeb 0
r 00004030 00000000 0 ffffbfcf 1
r 00005034 00000000 0 ffffafcb 1
r 00004038 00000000 0 ffffbfc7 0
r 0000603c 00000000 0 ffff9fc3 1
r 00004030 00000000 0 ffffbfcf 0
r 00005030 00000000 0 ffffafcf 1
r 00004034 00000000 0 ffffbfcb 0
r 00006030 00000000 0 ffff9fcf 1
i 00001000 00000000 0 00000000 0
r 00001008 00000000 0 ffff5678 1
r 0000100c 00000000 0 ffffeff3 0
w 00004030 0badcafe f 00000000 0
r 00004030 00000000 0 0badcafe 0

//--- tb.f
verilog/dcache_pkg.sv
verilog/dcache_ram.sv
verilog/dcache_lru.sv
verilog/dcache_req_buf.sv
verilog/dcache_datapath.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
verification/dcache_clk_gen.sv
verification/dcache_tb.sv

//--- run.sh
#!/bin/sh
# build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/100ps -f tb.f --top-module dcache_tb -o dcache_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/dcache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0
